// ==== dv/husky_reg_chk.sv ====
module husky_reg_chk (
   input logic       clk_usb_buf,
   input logic       rst_n_i,
   input logic       req_valid_i,
   input logic       busy_i,
   input logic       pop_i,
   input logic       rd_valid_i,
   input logic       npower_i,
   input logic [3:0] tio_oe_i
);

   // Issue only with a credit in hand
   a_credit: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      req_valid_i |-> !busy_i)
      else $error("request issued with zero credits");

   // Back-to-back read results need back-to-back pops
   a_rd_pops: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      (rd_valid_i && $past(rd_valid_i)) |-> ($past(pop_i, 1) && $past(pop_i, 2)))
      else $error("two read results without two pops");

   a_hiz: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      npower_i |-> (tio_oe_i == 4'h0))
      else $error("output enable active while target unpowered");

endmodule

bind husky_reg_top husky_reg_chk chk0 (
   .clk_usb_buf (clk_usb_buf),
   .rst_n_i     (rst_n_i),
   .req_valid_i (req_valid),
   .busy_i      (busy_o),
   .pop_i       (pop),
   .rd_valid_i  (rd_valid_o),
   .npower_i    (u_reg_ctrl.u_reg_tio.npower),
   .tio_oe_i    (tio_oe_o)
);

// ==== dv/tb_clkgen.sv ====
module tb_clkgen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o; // Period 20
   end

   // Reset held low for 8 rising edges
   initial begin
      rst_n_o = 1'b0;
      repeat (8) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// ==== dv/tb_monitor.sv ====
module tb_monitor #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                        clk_usb_buf,
   input  logic                        rst_n_i,
   input  logic                        rd_valid_i,
   input  logic [7:0]                  rd_data_i,
   input  logic                        busy_i,
   input  logic                        drop_i,
   input  logic [31:0]                 offset_i,
   input  logic [15:0]                 width_i,
   input  husky_reg_pkg::glitch_ctrl_u ctrl_i,
   input  logic [3:0]                  val_i,
   input  logic [3:0]                  oe_i,
   input  logic                        req_valid_i,
   input  logic                        pop_i,
   input  logic                        exp_push_i,
   input  logic [7:0]                  exp_byte_i,
   input  logic                        chk_i,
   input  logic [31:0]                 exp_off_i,
   input  logic [15:0]                 exp_wid_i,
   input  logic [7:0]                  exp_ctrl_i,
   input  logic [3:0]                  exp_val_i,
   input  logic [3:0]                  exp_oe_i,
   input  logic                        exp_drop_i,
   input  logic                        test_end_i,
   input  int                          test_num_i,
   input  logic                        done_i,
   output int                          err_cnt_o
);

   logic [7:0] rd_q[$];   // Expected read bytes in issue order
   logic [7:0] want;
   int         outstanding;
   int         errors = 0;
   int         errs_start = 0;
   int         n_pass = 0;
   int         n_fail = 0;

   assign err_cnt_o = errors;

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp_v);
      if (got !== exp_v) begin
         $display("error %s got %h expected %h", name, got, exp_v);
         errors++;
      end
   endtask

   always @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         outstanding <= 0;
      end else begin
         if (exp_push_i)
            rd_q.push_back(exp_byte_i);
         if (rd_valid_i) begin
            if (rd_q.size() == 0) begin
               $display("read result returned with no read pending");
               errors++;
            end else begin
               want = rd_q.pop_front();
               compare("rd_data_o", 32'(rd_data_i), 32'(want));
            end
         end
         // Busy exactly when every buffer slot is spoken for
         if (busy_i !== (outstanding == FIFO_DEPTH)) begin
            $display("busy_o is %0b with %0d requests outstanding", busy_i, outstanding);
            errors++;
         end
         outstanding <= outstanding + int'(req_valid_i) - int'(pop_i);
         if (chk_i) begin
            compare("glitch_offset_o", offset_i, exp_off_i);
            compare("glitch_width_o", 32'(width_i), 32'(exp_wid_i));
            compare("glitch_ctrl_o.arm", 32'(ctrl_i.fld.arm), 32'(exp_ctrl_i[7]));
            compare("glitch_ctrl_o.trig_src", 32'(ctrl_i.fld.trig_src), 32'(exp_ctrl_i[6:4]));
            compare("glitch_ctrl_o.mode", 32'(ctrl_i.fld.mode), 32'(exp_ctrl_i[3:2]));
            compare("tio_value_o", 32'(val_i), 32'(exp_val_i));
            compare("tio_oe_o", 32'(oe_i), 32'(exp_oe_i));
            // Sticky once a strobe met a full buffer
            compare("drop_o", 32'(drop_i), 32'(exp_drop_i));
         end
         if (test_end_i) begin
            if (errors == errs_start) begin
               n_pass++;
               $display("test %0d passed", test_num_i);
            end else begin
               n_fail++;
               $display("test %0d failed with %0d errors", test_num_i, errors - errs_start);
            end
            errs_start = errors;
         end
         if (done_i) begin
            if (rd_q.size() != 0) begin
               $display("%0d expected read results never arrived", rd_q.size());
               errors++;
            end
            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     n_pass + n_fail, n_pass, n_fail, errors);
         end
      end
   end

endmodule

// ==== dv/tb_top.sv ====
module tb_top;

   localparam int FIFO_DEPTH = 1; // One slot so full-rate strobes meet back-pressure
   localparam logic [1:0] OP_IDLE = 2'd0;
   localparam logic [1:0] OP_WR   = 2'd1;
   localparam logic [1:0] OP_RD   = 2'd2;
   localparam logic [1:0] OP_FAST = 2'd3; // Write with 1-cycle strobe

   typedef struct packed {
      logic [1:0]  op;
      logic [7:0]  addr;
      logic [7:0]  data;
      logic        cont;     // Stays in current burst
      logic [7:0]  exp_rd;
      logic        chk;      // Compare outputs after this entry
      logic        last;     // Closes a test
      logic [31:0] exp_off;
      logic [15:0] exp_wid;
      logic [7:0]  exp_ctrl;
      logic [3:0]  exp_val;
      logic [3:0]  exp_oe;
      logic        exp_drop;
   } entry_t;

   logic        clk_usb_buf, rst_n_i;
   logic [7:0]  usb_addr, usb_din;
   logic        usb_wrn, usb_rdn, usb_cen;
   logic        busy, drop, rd_valid;
   logic [7:0]  rd_data;
   logic [31:0] glitch_offset;
   logic [15:0] glitch_width;
   husky_reg_pkg::glitch_ctrl_u glitch_ctrl;
   logic [3:0]  tio_value, tio_oe;

   logic        exp_push = 1'b0;
   logic [7:0]  exp_byte = 8'h00;
   logic        chk_en = 1'b0;
   logic        test_end = 1'b0;
   logic        all_done = 1'b0;
   int          test_num = 1;
   int          err_cnt;
   entry_t      cur = '0; // Entry being applied and its expected outputs
   entry_t      tbl[$];
   logic [31:0] cur_off = '0;
   logic [15:0] cur_wid = '0;
   logic [7:0]  cur_ctrl = '0;
   logic [3:0]  cur_val = '0, cur_oe = '0;
   logic        cur_drop = 1'b0;
   int          limit = 1000;
   int          cycles = 0;

   tb_clkgen clkgen0 (.clk_o(clk_usb_buf), .rst_n_o(rst_n_i));

   husky_reg_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
      .clk_usb_buf (clk_usb_buf), .rst_n_i (rst_n_i),
      .usb_addr_i (usb_addr), .usb_din_i (usb_din),
      .usb_wrn_i (usb_wrn), .usb_rdn_i (usb_rdn), .usb_cen_i (usb_cen),
      .busy_o (busy), .drop_o (drop), .rd_data_o (rd_data), .rd_valid_o (rd_valid),
      .glitch_offset_o (glitch_offset), .glitch_width_o (glitch_width),
      .glitch_ctrl_o (glitch_ctrl), .tio_value_o (tio_value), .tio_oe_o (tio_oe)
   );

   tb_monitor #(.FIFO_DEPTH(FIFO_DEPTH)) mon0 (
      .clk_usb_buf (clk_usb_buf), .rst_n_i (rst_n_i),
      .rd_valid_i (rd_valid), .rd_data_i (rd_data), .busy_i (busy), .drop_i (drop),
      .offset_i (glitch_offset), .width_i (glitch_width), .ctrl_i (glitch_ctrl),
      .val_i (tio_value), .oe_i (tio_oe),
      .req_valid_i (dut0.req_valid), .pop_i (dut0.pop),
      .exp_push_i (exp_push), .exp_byte_i (exp_byte), .chk_i (chk_en),
      .exp_off_i (cur.exp_off), .exp_wid_i (cur.exp_wid), .exp_ctrl_i (cur.exp_ctrl),
      .exp_val_i (cur.exp_val), .exp_oe_i (cur.exp_oe), .exp_drop_i (cur.exp_drop),
      .test_end_i (test_end), .test_num_i (test_num), .done_i (all_done),
      .err_cnt_o (err_cnt)
   );

   function automatic entry_t ent(input logic [1:0] op, input logic [7:0] addr,
                                  input logic [7:0] data, input logic cont,
                                  input logic [7:0] exp_rd, input logic chk, input logic last);
      entry_t e;
      e = '{op: op, addr: addr, data: data, cont: cont, exp_rd: exp_rd, chk: chk,
            last: last, exp_off: cur_off, exp_wid: cur_wid, exp_ctrl: cur_ctrl,
            exp_val: cur_val, exp_oe: cur_oe, exp_drop: cur_drop};
      return e;
   endfunction

   // One strobe with wrn or rdn low for width cycles then high for width cycles
   task automatic bus_access(input entry_t e, input int width);
      if (!e.cont) begin
         @(posedge clk_usb_buf);
         usb_cen <= 1'b1; // Deselect closes the burst
         @(posedge clk_usb_buf);
      end
      @(negedge clk_usb_buf);
      while (busy && e.op != OP_FAST)
         @(negedge clk_usb_buf);
      @(posedge clk_usb_buf);
      usb_addr <= e.addr;
      usb_din  <= e.data;
      usb_cen  <= 1'b0;
      if (e.op == OP_RD) begin
         usb_rdn  <= 1'b0;
         exp_push <= 1'b1;
         exp_byte <= e.exp_rd;
      end else begin
         usb_wrn <= 1'b1 ^ 1'b1;
      end
      @(posedge clk_usb_buf);
      exp_push <= 1'b0;
      repeat (width - 1) @(posedge clk_usb_buf);
      usb_wrn <= 1'b1;
      usb_rdn <= 1'b1;
      repeat (width - 1) @(posedge clk_usb_buf); // Next call's edge wait ends the high phase
   endtask

   always @(posedge clk_usb_buf) begin
      cycles++;
      if (cycles >= limit) begin
         $display("Timeout: run did not finish within %0d cycles", limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      logic [7:0] rb[4];
      logic [7:0] wb[2];
      logic [7:0] fb[4];
      entry_t     e;
      usb_addr = 8'h00;
      usb_din  = 8'h00;
      usb_wrn  = 1'b1;
      usb_rdn  = 1'b1;
      usb_cen  = 1'b1;
      void'($urandom(32'h05c7230c));
      for (int i = 0; i < 4; i++) rb[i] = 8'($urandom);
      for (int i = 0; i < 2; i++) wb[i] = 8'($urandom);
      for (int i = 0; i < 4; i++) fb[i] = 8'($urandom);

      // Test 1 reads everything as zero out of reset
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_OFFSET, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_WIDTH, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_CTRL, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_TIO_DRIVE, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_TIO_POWER, 8'h00, 1'b0, 8'h00, 1'b1, 1'b1));
      // Test 2 covers little-endian bursts and an out-of-range third width byte
      cur_off = {rb[3], rb[2], rb[1], rb[0]};
      cur_wid = {wb[1], wb[0]};
      for (int i = 0; i < 4; i++)
         tbl.push_back(ent(OP_WR, husky_reg_pkg::ADDR_GLITCH_OFFSET, rb[i], i != 0, 8'h00,
                           1'b0, 1'b0));
      tbl.push_back(ent(OP_WR, husky_reg_pkg::ADDR_GLITCH_WIDTH, wb[0], 1'b0, 8'h00, 1'b0, 1'b0));
      tbl.push_back(ent(OP_WR, husky_reg_pkg::ADDR_GLITCH_WIDTH, wb[1], 1'b1, 8'h00, 1'b0, 1'b0));
      tbl.push_back(ent(OP_WR, husky_reg_pkg::ADDR_GLITCH_WIDTH, 8'hEE, 1'b1, 8'h00, 1'b1, 1'b0));
      for (int i = 0; i < 4; i++)
         tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_OFFSET, 8'h00, i != 0, rb[i],
                           1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_WIDTH, 8'h00, 1'b0, wb[0], 1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_WIDTH, 8'h00, 1'b1, wb[1], 1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_WIDTH, 8'h00, 1'b1, 8'h00, 1'b0, 1'b1));
      // Test 3 uses arm=1 trig_src=3 mode=1 reserved=2
      cur_ctrl = 8'hB6;
      tbl.push_back(ent(OP_WR, husky_reg_pkg::ADDR_GLITCH_CTRL, 8'hB6, 1'b0, 8'h00, 1'b1, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_CTRL, 8'h00, 1'b0, 8'hB6, 1'b0, 1'b1));
      // Test 4 covers the npower override on the enables
      cur_val = 4'h5;
      cur_oe  = 4'hA;
      tbl.push_back(ent(OP_WR, husky_reg_pkg::ADDR_TIO_DRIVE, 8'hA5, 1'b0, 8'h00, 1'b1, 1'b0));
      cur_oe = 4'h0;
      tbl.push_back(ent(OP_WR, husky_reg_pkg::ADDR_TIO_POWER, 8'h01, 1'b0, 8'h00, 1'b1, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_TIO_DRIVE, 8'h00, 1'b0, 8'hA5, 1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_TIO_POWER, 8'h00, 1'b0, 8'h01, 1'b0, 1'b0));
      cur_oe = 4'hA;
      tbl.push_back(ent(OP_WR, husky_reg_pkg::ADDR_TIO_POWER, 8'h00, 1'b0, 8'h00, 1'b1, 1'b1));
      // Test 5 reads unmapped addresses
      tbl.push_back(ent(OP_RD, 8'h33, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, 8'h7F, 8'h00, 1'b0, 8'h00, 1'b0, 1'b1));
      // Test 6 sends strobes 2 cycles apart into the one-entry buffer
      // Each issue holds the only credit for one cycle, so strobes 2 and 4 are dropped
      cur_off  = {rb[3], fb[2], rb[1], fb[0]};
      cur_drop = 1'b1;
      for (int i = 0; i < 4; i++)
         tbl.push_back(ent(OP_FAST, husky_reg_pkg::ADDR_GLITCH_OFFSET, fb[i], i != 0, 8'h00,
                           i == 3, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_OFFSET, 8'h00, 1'b0, fb[0], 1'b0, 1'b0));
      tbl.push_back(ent(OP_RD, husky_reg_pkg::ADDR_GLITCH_OFFSET, 8'h00, 1'b1, rb[1], 1'b0, 1'b0));
      tbl.push_back(ent(OP_IDLE, 8'h00, 8'h00, 1'b0, 8'h00, 1'b0, 1'b1));

      limit = tbl.size() * 8 + 200;

      @(posedge rst_n_i);
      @(posedge clk_usb_buf);
      foreach (tbl[k]) begin
         e = tbl[k];
         if (e.op == OP_IDLE)
            repeat (4) @(posedge clk_usb_buf);
         else
            bus_access(e, (e.op == OP_FAST) ? 1 : 2);
         if (e.chk) begin
            repeat (3) @(posedge clk_usb_buf); // Write lands 4 cycles after the strobe
            cur    <= e;
            chk_en <= 1'b1;
            @(posedge clk_usb_buf);
            chk_en <= 1'b0;
         end
         if (e.last) begin
            repeat (6) @(posedge clk_usb_buf); // Let reads drain
            test_end <= 1'b1;
            @(posedge clk_usb_buf);
            test_end <= 1'b0;
            test_num <= test_num + 1;
         end
      end
      repeat (4) @(posedge clk_usb_buf);
      all_done <= 1'b1;
      @(posedge clk_usb_buf);
      all_done <= 1'b0;
      repeat (2) @(posedge clk_usb_buf);
      if (err_cnt == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile with Verilator and run the testbench
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_top -o tb_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "Simulation exited with an error, see sim.log"
   exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

// ==== src.f ====
src/husky_reg_pkg.sv
src/usb_bus_front.sv
src/cmd_fifo.sv
src/reg_glitch.sv
src/reg_target_io.sv
src/reg_access_ctrl.sv
src/husky_reg_top.sv
dv/husky_reg_chk.sv
dv/tb_clkgen.sv
dv/tb_monitor.sv
dv/tb_top.sv

// ==== src/cmd_fifo.sv ====
module cmd_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                      clk_usb_buf,
   input  logic                      rst_n_i,
   input  logic                      push_i,
   input  husky_reg_pkg::reg_req_t   push_data_i,
   input  logic                      pop_i,
   output logic                      not_empty_o,
   output husky_reg_pkg::reg_req_t   head_o,
   output logic                      credit_return_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   husky_reg_pkg::reg_req_t mem [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_pop;

   assign not_empty_o     = (count_q != '0);
   assign head_o          = mem[rd_ptr_q];
   assign do_pop          = pop_i && not_empty_o;
   assign credit_return_o = do_pop; // One credit back per popped entry

   // Storage, no overflow check since the writer holds credits
   always_ff @(posedge clk_usb_buf) begin
      if (push_i)
         mem[wr_ptr_q] <= push_data_i;
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            // Explicit wrap, depth need not be a power of two
            wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push_i, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q; // Both or neither
         endcase
      end
   end

endmodule

// ==== src/husky_reg_pkg.sv ====
package husky_reg_pkg;

   // Byte counter inside a burst, wraps
   localparam int BYTECNT_W = 2;

   // Register map
   localparam logic [7:0] ADDR_GLITCH_OFFSET = 8'h10; // 4 bytes, little-endian
   localparam logic [7:0] ADDR_GLITCH_WIDTH  = 8'h11; // 2 bytes, little-endian
   localparam logic [7:0] ADDR_GLITCH_CTRL   = 8'h12; // 1 byte
   localparam logic [7:0] ADDR_TIO_DRIVE     = 8'h20; // [3:0] value, [7:4] enable
   localparam logic [7:0] ADDR_TIO_POWER     = 8'h21; // Bit 0 is npower

   // Register sizes in bytes
   localparam int GLITCH_OFFSET_BYTES = 4;
   localparam int GLITCH_WIDTH_BYTES  = 2;

   // One queued bus access, 19 bits
   typedef struct packed {
      logic                 is_read;
      logic [7:0]           addr;
      logic [BYTECNT_W-1:0] bytecnt;
      logic [7:0]           data;
   } reg_req_t;

   // Glitch control byte, raw for the register file, fields for the glitch logic
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic       arm;      // Bit 7
         logic [2:0] trig_src; // Bits 6:4
         logic [1:0] mode;     // Bits 3:2
         logic [1:0] reserved; // Bits 1:0
      } fld;
   } glitch_ctrl_u;

endpackage

// ==== src/husky_reg_top.sv ====
module husky_reg_top #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                          clk_usb_buf,
   input  logic                          rst_n_i,
   input  logic [7:0]                    usb_addr_i,
   input  logic [7:0]                    usb_din_i,
   input  logic                          usb_wrn_i,
   input  logic                          usb_rdn_i,
   input  logic                          usb_cen_i,
   output logic                          busy_o,
   output logic                          drop_o,
   output logic [7:0]                    rd_data_o,
   output logic                          rd_valid_o,
   output logic [31:0]                   glitch_offset_o,
   output logic [15:0]                   glitch_width_o,
   output husky_reg_pkg::glitch_ctrl_u   glitch_ctrl_o,
   output logic [3:0]                    tio_value_o,
   output logic [3:0]                    tio_oe_o
);

   logic                    req_valid;
   husky_reg_pkg::reg_req_t req;
   logic                    credit_return;
   logic                    not_empty;
   husky_reg_pkg::reg_req_t head;
   logic                    pop;

   usb_bus_front #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_bus_front (
      .clk_usb_buf     (clk_usb_buf),
      .rst_n_i         (rst_n_i),
      .usb_addr_i      (usb_addr_i),
      .usb_din_i       (usb_din_i),
      .usb_wrn_i       (usb_wrn_i),
      .usb_rdn_i       (usb_rdn_i),
      .usb_cen_i       (usb_cen_i),
      .credit_return_i (credit_return),
      .req_valid_o     (req_valid),
      .req_o           (req),
      .busy_o          (busy_o),
      .drop_o          (drop_o)
   );

   // Depth here must match the front end credit count
   cmd_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_cmd_fifo (
      .clk_usb_buf     (clk_usb_buf),
      .rst_n_i         (rst_n_i),
      .push_i          (req_valid),
      .push_data_i     (req),
      .pop_i           (pop),
      .not_empty_o     (not_empty),
      .head_o          (head),
      .credit_return_o (credit_return)
   );

   reg_access_ctrl u_reg_ctrl (
      .clk_usb_buf     (clk_usb_buf),
      .rst_n_i         (rst_n_i),
      .not_empty_i     (not_empty),
      .head_i          (head),
      .pop_o           (pop),
      .rd_data_o       (rd_data_o),
      .rd_valid_o      (rd_valid_o),
      .glitch_offset_o (glitch_offset_o),
      .glitch_width_o  (glitch_width_o),
      .glitch_ctrl_o   (glitch_ctrl_o),
      .tio_value_o     (tio_value_o),
      .tio_oe_o        (tio_oe_o)
   );

endmodule

// ==== src/reg_access_ctrl.sv ====
module reg_access_ctrl (
   input  logic                          clk_usb_buf,
   input  logic                          rst_n_i,
   input  logic                          not_empty_i,
   input  husky_reg_pkg::reg_req_t       head_i,
   output logic                          pop_o,
   output logic [7:0]                    rd_data_o,
   output logic                          rd_valid_o,
   output logic [31:0]                   glitch_offset_o,
   output logic [15:0]                   glitch_width_o,
   output husky_reg_pkg::glitch_ctrl_u   glitch_ctrl_o,
   output logic [3:0]                    tio_value_o,
   output logic [3:0]                    tio_oe_o
);

   logic       wr_en;
   logic       rd_en;
   logic [7:0] rd_byte_glitch;
   logic [7:0] rd_byte_tio;

   // Take one entry every cycle one is waiting
   assign pop_o = not_empty_i;
   assign wr_en = pop_o && !head_i.is_read;
   assign rd_en = pop_o && head_i.is_read;

   reg_glitch u_reg_glitch (
      .clk_usb_buf     (clk_usb_buf),
      .rst_n_i         (rst_n_i),
      .wr_en_i         (wr_en),
      .rd_en_i         (rd_en),
      .req_i           (head_i),
      .rd_byte_o       (rd_byte_glitch),
      .glitch_offset_o (glitch_offset_o),
      .glitch_width_o  (glitch_width_o),
      .glitch_ctrl_o   (glitch_ctrl_o)
   );

   reg_target_io u_reg_tio (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .wr_en_i     (wr_en),
      .rd_en_i     (rd_en),
      .req_i       (head_i),
      .rd_byte_o   (rd_byte_tio),
      .tio_value_o (tio_value_o),
      .tio_oe_o    (tio_oe_o)
   );

   // Blocks return zero off their own addresses, so OR them
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i)
         rd_valid_o <= 1'b0;
      else
         rd_valid_o <= rd_en;
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rd_en)
         rd_data_o <= rd_byte_glitch | rd_byte_tio; // Held until next read
   end

endmodule

// ==== src/reg_glitch.sv ====
module reg_glitch (
   input  logic                          clk_usb_buf,
   input  logic                          rst_n_i,
   input  logic                          wr_en_i,
   input  logic                          rd_en_i,
   input  husky_reg_pkg::reg_req_t       req_i,
   output logic [7:0]                    rd_byte_o,
   output logic [31:0]                   glitch_offset_o,
   output logic [15:0]                   glitch_width_o,
   output husky_reg_pkg::glitch_ctrl_u   glitch_ctrl_o
);

   logic [31:0]                 offset_q;
   logic [15:0]                 width_q;
   husky_reg_pkg::glitch_ctrl_u ctrl_q;
   logic                        offset_hit, width_hit, ctrl_hit;

   // Address match plus a byte index inside the register
   assign offset_hit = (req_i.addr == husky_reg_pkg::ADDR_GLITCH_OFFSET) &&
                       (int'(req_i.bytecnt) < husky_reg_pkg::GLITCH_OFFSET_BYTES);
   assign width_hit  = (req_i.addr == husky_reg_pkg::ADDR_GLITCH_WIDTH) &&
                       (int'(req_i.bytecnt) < husky_reg_pkg::GLITCH_WIDTH_BYTES);
   assign ctrl_hit   = (req_i.addr == husky_reg_pkg::ADDR_GLITCH_CTRL) &&
                       (req_i.bytecnt == '0);

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         offset_q   <= '0;
         width_q    <= '0;
         ctrl_q.raw <= '0;
      end else if (wr_en_i) begin
         if (offset_hit)
            offset_q[req_i.bytecnt*8 +: 8] <= req_i.data; // Byte 0 is LSB
         if (width_hit)
            width_q[req_i.bytecnt*8 +: 8] <= req_i.data;
         if (ctrl_hit)
            ctrl_q.raw <= req_i.data; // Stored as a plain byte
      end
   end

   // Read mux, zero when not addressed
   always_comb begin
      rd_byte_o = '0;
      if (rd_en_i) begin
         if (offset_hit)
            rd_byte_o = offset_q[req_i.bytecnt*8 +: 8];
         else if (width_hit)
            rd_byte_o = width_q[req_i.bytecnt*8 +: 8];
         else if (ctrl_hit)
            rd_byte_o = ctrl_q.raw;
      end
   end

   assign glitch_offset_o = offset_q;
   assign glitch_width_o  = width_q;
   assign glitch_ctrl_o   = ctrl_q; // Fields decoded downstream

endmodule

// ==== src/reg_target_io.sv ====
module reg_target_io (
   input  logic                      clk_usb_buf,
   input  logic                      rst_n_i,
   input  logic                      wr_en_i,
   input  logic                      rd_en_i,
   input  husky_reg_pkg::reg_req_t   req_i,
   output logic [7:0]                rd_byte_o,
   output logic [3:0]                tio_value_o,
   output logic [3:0]                tio_oe_o
);

   logic [7:0] drive_q;   // [3:0] value, [7:4] enable
   logic [7:0] power_q;
   logic       npower;
   logic       drive_hit, power_hit;

   // Single-byte registers, only byte 0 is mapped
   assign drive_hit = (req_i.addr == husky_reg_pkg::ADDR_TIO_DRIVE) && (req_i.bytecnt == '0);
   assign power_hit = (req_i.addr == husky_reg_pkg::ADDR_TIO_POWER) && (req_i.bytecnt == '0);

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         drive_q <= '0;
         power_q <= '0;
      end else if (wr_en_i) begin
         if (drive_hit)
            drive_q <= req_i.data;
         if (power_hit)
            power_q <= req_i.data;
      end
   end

   assign npower = power_q[0];

   // Target unpowered, so all pins go high-Z
   assign tio_value_o = drive_q[3:0];
   assign tio_oe_o    = npower ? 4'h0 : drive_q[7:4];

   // Readback shows stored enables, not the overridden ones
   assign rd_byte_o = !rd_en_i  ? 8'h00 :
                      drive_hit ? drive_q :
                      power_hit ? power_q : 8'h00;

endmodule

// ==== src/usb_bus_front.sv ====
module usb_bus_front #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                      clk_usb_buf,
   input  logic                      rst_n_i,
   input  logic [7:0]                usb_addr_i,
   input  logic [7:0]                usb_din_i,
   input  logic                      usb_wrn_i,
   input  logic                      usb_rdn_i,
   input  logic                      usb_cen_i,
   input  logic                      credit_return_i,
   output logic                      req_valid_o,
   output husky_reg_pkg::reg_req_t   req_o,
   output logic                      busy_o,
   output logic                      drop_o
);

   localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

   logic [7:0] addr_q;
   logic [7:0] din_q;
   logic       wrn_q, rdn_q, cen_q;
   logic       wrn_d1, rdn_d1;   // Previous sample, for edge detect
   logic       wr_strobe, rd_strobe, strobe;
   logic       first_q;          // Next strobe starts a burst
   logic       new_burst;
   logic [7:0] last_addr_q;
   logic [husky_reg_pkg::BYTECNT_W-1:0] bytecnt_q;
   logic [husky_reg_pkg::BYTECNT_W-1:0] bytecnt_nxt;
   logic [CRED_W-1:0] credit_q;

   // Bus lines sampled once, strobes idle high
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         wrn_q  <= 1'b1;
         rdn_q  <= 1'b1;
         cen_q  <= 1'b1;
         wrn_d1 <= 1'b1;
         rdn_d1 <= 1'b1;
      end else begin
         wrn_q  <= usb_wrn_i;
         rdn_q  <= usb_rdn_i;
         cen_q  <= usb_cen_i;
         wrn_d1 <= wrn_q;
         rdn_d1 <= rdn_q;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      addr_q <= usb_addr_i;
      din_q  <= usb_din_i;
   end

   // Falling edge of wrn or rdn while selected
   assign wr_strobe = !cen_q && !wrn_q && wrn_d1;
   assign rd_strobe = !cen_q && !rdn_q && rdn_d1;
   assign strobe    = wr_strobe || rd_strobe;

   assign new_burst   = first_q || (addr_q != last_addr_q);
   assign bytecnt_nxt = new_burst ? '0 : bytecnt_q + 1'b1; // Wraps

   assign busy_o = (credit_q == '0);

   // Burst tracking, counts every strobe the host made
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         first_q     <= 1'b1;
         bytecnt_q   <= '0;
         last_addr_q <= '0;
      end else if (cen_q) begin
         first_q <= 1'b1; // Deselect ends the burst
      end else if (strobe) begin
         first_q     <= 1'b0;
         bytecnt_q   <= bytecnt_nxt;
         last_addr_q <= addr_q;
      end
   end

   // Issue, credits and sticky drop flag
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         req_valid_o <= 1'b0;
         credit_q    <= CRED_W'(FIFO_DEPTH);
         drop_o      <= 1'b0;
      end else begin
         req_valid_o <= strobe && !busy_o;
         if (strobe && busy_o)
            drop_o <= 1'b1;
         case ({req_valid_o, credit_return_i})
            2'b10:   credit_q <= credit_q - 1'b1; // Spent on issue
            2'b01:   credit_q <= credit_q + 1'b1; // Entry popped
            default: credit_q <= credit_q;
         endcase
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (strobe) begin
         req_o <= '{is_read: rd_strobe, addr: addr_q, bytecnt: bytecnt_nxt, data: din_q};
      end
   end

endmodule
